// File: dv/mul_trace.txt
# cmd funct3 word rs1 rs2 tag expected, all hex; idle drains, read checks the register file
issue 0 0 0000000000000003 0000000000000005 1 000000000000000f
issue 0 0 fffffffffffffffe 0000000000000003 2 fffffffffffffffa
issue 1 0 fffffffffffffffe 0000000000000003 3 ffffffffffffffff
issue 3 0 ffffffffffffffff ffffffffffffffff 4 fffffffffffffffe
issue 2 0 8000000000000000 ffffffffffffffff 5 8000000000000000
issue 1 0 8000000000000000 8000000000000000 6 4000000000000000
issue 0 1 ffffffff00000003 0000000500000004 7 000000000000000c
issue 0 1 00000000ffffffff 0000000000000007 8 fffffffffffffff9
issue 0 1 1234567840000000 0000000000000002 9 ffffffff80000000
issue 0 0 0000000000000006 0000000000000007 a 000000000000002a
issue 0 1 0000000000000002 0000000000000003 b 0000000000000006
idle 0 0 0 0 0 0
issue 0 0 0000000000000002 0000000000000002 c 0000000000000004
issue 0 0 0000000000000003 0000000000000003 d 0000000000000009
kill 0 0 0000000000000004 0000000000000004 e 0000000000000010
idle 0 0 0 0 0 0
issue 5 0 0000000000000007 0000000000000007 f 0000000000000031
issue 0 0 0000000000000009 0000000000000009 1 0000000000000051
idle 0 0 0 0 0 0
read 0 0 0 0 0 0000000000000000
read 0 0 0 0 1 0000000000000051
read 0 0 0 0 5 8000000000000000
read 0 0 0 0 9 ffffffff80000000
read 0 0 0 0 c 0000000000000004
read 0 0 0 0 d 0000000000000000
read 0 0 0 0 f 0000000000000000

// File: mul_subsys.f
hw/mul_pkg.sv
hw/mul_cpl_if.sv
hw/mul_unit.sv
hw/mul_result_fifo.sv
hw/mul_writeback.sv
hw/mul_subsys.sv
dv/tb_mul_subsys.sv

// File: Bender.yml
package:
  name: mul_subsys

sources:
  - hw/mul_pkg.sv
  - hw/mul_cpl_if.sv
  - hw/mul_unit.sv
  - hw/mul_result_fifo.sv
  - hw/mul_writeback.sv
  - hw/mul_subsys.sv
  - target: test
    files:
      - dv/tb_mul_subsys.sv

// File: dv/tb_mul_subsys.sv
// ------------------------------
// Multiply subsystem testbench
// Replays the trace file and scoreboards every retirement
// ------------------------------
module tb_mul_subsys
    import mul_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_LIMIT  = 50;  // Cycles allowed for pending results
    localparam int QUIET_CYCLES = 8;   // Window for stray retirements

    logic    clk_i = 1'b0;
    logic    rstn_i;
    logic    issue_i;
    funct3_t funct3_i;
    logic    word_i;
    xlen_t   rs1_i;
    xlen_t   rs2_i;
    tag_t    tag_i;
    logic    kill_i;
    tag_t    rd_addr_i;
    logic    wb_valid_o;
    tag_t    wb_tag_o;
    xlen_t   wb_data_o;
    xlen_t   rd_data_o;

    // Scoreboard indexed by destination tag
    logic    exp_valid [NUM_TAGS];
    xlen_t   exp_data  [NUM_TAGS];
    int      pending;
    logic    last_issued;  // Issue in the previous cycle
    tag_t    last_tag;

    always #4 clk_i = ~clk_i;

    mul_subsys mul_subsys_inst (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // One cycle of stimulus just after the rising edge
    task automatic drive_cycle(input logic issue, input logic kill, input funct3_t f3,
                               input logic wd, input xlen_t a, input xlen_t b, input tag_t t);
        @(posedge clk_i);
        #1;
        issue_i   = issue;
        kill_i    = kill;
        funct3_i  = f3;
        word_i    = wd;
        rs1_i     = a;
        rs2_i     = b;
        tag_i     = t;
        rd_addr_i = t;
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, '0, '0);
        while (pending != 0) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                stop_with_failure($sformatf("Timeout with %0d results not retired", pending));
            end
        end
        repeat (QUIET_CYCLES) @(posedge clk_i);  // Flushed ops must stay silent
    endtask

    // Retirement monitor, sampled mid-cycle
    always @(negedge clk_i) begin
        if (rstn_i && wb_valid_o) begin
            if (!exp_valid[wb_tag_o]) begin
                stop_with_failure($sformatf("Unexpected retirement of tag %0d", wb_tag_o));
            end else begin
                check_value($sformatf("retire tag %0d", wb_tag_o), exp_data[wb_tag_o], wb_data_o);
                exp_valid[wb_tag_o] = 1'b0;
                pending--;
            end
        end
    end

    initial begin
        int               fd;
        int               code;
        logic             done;
        logic [63:0]      cmd;
        logic [8*128-1:0] rest;
        funct3_t          f3;
        logic             wd;
        xlen_t            a;
        xlen_t            b;
        tag_t             t;
        xlen_t            expected;

        rstn_i    = 1'b0;
        issue_i   = 1'b0;
        kill_i    = 1'b0;
        funct3_i  = '0;
        word_i    = 1'b0;
        rs1_i     = '0;
        rs2_i     = '0;
        tag_i     = '0;
        rd_addr_i = '0;
        pending     = 0;
        last_issued = 1'b0;
        last_tag    = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            exp_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        fd = $fopen("dv/mul_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the trace file dv/mul_trace.txt");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(rest, fd);  // Column legend
            end else begin
                code = $fscanf(fd, " %h %h %h %h %h %h", f3, wd, a, b, t, expected);
                if (code != 6) begin
                    stop_with_failure("A trace line has missing fields");
                end
                case (cmd)
                    "issue": begin
                        drive_cycle(1'b1, 1'b0, f3, wd, a, b, t);
                        if (!f3[F3_DIV_BIT]) begin  // Division codes never retire
                            exp_valid[t] = 1'b1;
                            exp_data[t]  = expected;
                            pending++;
                        end
                    end
                    "kill": begin
                        drive_cycle(1'b1, 1'b1, f3, wd, a, b, t);
                        if (last_issued && exp_valid[last_tag]) begin
                            exp_valid[last_tag] = 1'b0;  // Previous issue is flushed too
                            pending--;
                        end
                    end
                    "idle": drain_results();
                    "read": begin
                        drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, '0, t);
                        @(negedge clk_i);
                        check_value($sformatf("read tag %0d", t), expected, rd_data_o);
                    end
                    default: stop_with_failure("The trace holds an unknown command");
                endcase
                last_issued = (cmd == "issue");
                last_tag    = t;
            end
        end
        $fclose(fd);
        drain_results();
        if (pending == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure("Results were still pending at the end of the trace");
        end
    end

endmodule

// File: hw/mul_subsys.sv
// ------------------------------
// Multiply subsystem top
// Multiplier, result buffer and writeback
// ------------------------------
module mul_subsys
    import mul_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    issue_i,
    input  funct3_t funct3_i,
    input  logic    word_i,
    input  xlen_t   rs1_i,
    input  xlen_t   rs2_i,
    input  tag_t    tag_i,
    input  logic    kill_i,
    input  tag_t    rd_addr_i,
    output logic    wb_valid_o,
    output tag_t    wb_tag_o,
    output xlen_t   wb_data_o,
    output xlen_t   rd_data_o
);

    logic fifo_pop;
    logic fifo_not_empty;
    cpl_t fifo_head;

    mul_cpl_if cpl_if ();

    mul_unit mul_unit_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .kill_i   (kill_i),
        .issue_i  (issue_i),
        .funct3_i (funct3_i),
        .word_i   (word_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .tag_i    (tag_i),
        .cpl      (cpl_if.unit)
    );

    mul_result_fifo mul_result_fifo_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cpl         (cpl_if.fifo),
        .pop_i       (fifo_pop),
        .not_empty_o (fifo_not_empty),
        .head_o      (fifo_head)
    );

    mul_writeback mul_writeback_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .not_empty_i (fifo_not_empty),
        .head_i      (fifo_head),
        .pop_o       (fifo_pop),
        .wb_valid_o  (wb_valid_o),
        .wb_tag_o    (wb_tag_o),
        .wb_data_o   (wb_data_o),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o)
    );

endmodule

// File: hw/mul_writeback.sv
// ------------------------------
// Multiply writeback
// Retires one result per cycle into the destination registers
// ------------------------------
module mul_writeback
    import mul_pkg::*;
(
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  not_empty_i,
    input  cpl_t  head_i,
    output logic  pop_o,
    output logic  wb_valid_o,
    output tag_t  wb_tag_o,
    output xlen_t wb_data_o,
    input  tag_t  rd_addr_i,
    output xlen_t rd_data_o
);

    xlen_t regfile [NUM_TAGS];

    assign pop_o = not_empty_i;  // Drain every cycle there is a result

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_o <= 1'b0;
            for (int i = 0; i < NUM_TAGS; i++) begin
                regfile[i] <= '0;
            end
        end else begin
            wb_valid_o <= not_empty_i;
            if (not_empty_i) begin
                regfile[head_i.tag] <= head_i.data;
            end
        end
    end

    // Retirement report, same edge as the register write
    always_ff @(posedge clk_i) begin
        if (not_empty_i) begin
            wb_tag_o  <= head_i.tag;
            wb_data_o <= head_i.data;
        end
    end

    assign rd_data_o = regfile[rd_addr_i];

endmodule

// File: hw/mul_result_fifo.sv
// ------------------------------
// Result buffer
// Two completions in, one result out per cycle
// ------------------------------
module mul_result_fifo
    import mul_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    mul_cpl_if.fifo cpl,
    input  logic    pop_i,
    output logic    not_empty_o,
    output cpl_t    head_o
);

    cpl_t                  mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W-1:0] full_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic [FIFO_CNT_W-1:0] num_wr;
    logic                  do_pop;

    assign num_wr   = FIFO_CNT_W'(cpl.word_valid) + FIFO_CNT_W'(cpl.full_valid);
    assign do_pop   = pop_i & not_empty_o;
    assign full_ptr = wr_ptr + FIFO_PTR_W'(cpl.word_valid);  // Slot after the word entry

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + num_wr[FIFO_PTR_W-1:0];
            rd_ptr <= rd_ptr + FIFO_PTR_W'(do_pop);
            count  <= count + num_wr - FIFO_CNT_W'(do_pop);
        end
    end

    // Word lane goes in first
    always_ff @(posedge clk_i) begin
        if (cpl.word_valid) begin
            mem[wr_ptr] <= cpl.word_cpl;
        end
        if (cpl.full_valid) begin
            mem[full_ptr] <= cpl.full_cpl;
        end
    end

    assign not_empty_o = (count != '0);
    assign head_o      = mem[rd_ptr];  // Head seen before the pop edge

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (cpl.word_valid || cpl.full_valid) |->
            int'(count) + int'(num_wr) - int'(do_pop) <= FIFO_DEPTH);

    // Writeback only pops what is there
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> not_empty_o);

endmodule

// File: hw/mul_unit.sv
// ------------------------------
// Two-stage integer multiplier
// Word forms complete after stage one, full forms after stage two
// ------------------------------
module mul_unit
    import mul_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    kill_i,    // Flush both stages
    input  logic    issue_i,
    input  funct3_t funct3_i,
    input  logic    word_i,
    input  xlen_t   rs1_i,
    input  xlen_t   rs2_i,
    input  tag_t    tag_i,
    mul_cpl_if.unit cpl
);

    logic             issue_ok;
    mul_kind_e        kind;
    xlen_t            op1;
    xlen_t            op2;
    logic             sign1;
    logic             sign2;

    logic             s1_valid;
    logic             s1_word;
    logic             s1_neg;
    mul_kind_e        s1_kind;
    tag_t             s1_tag;
    xlen_t            s1_mag1;
    xlen_t            s1_mag2;
    pp_t              pp_lo;
    pp_t              pp_hi;
    logic [HALF_XLEN-1:0] word_lo;

    logic             s2_valid;
    logic             s2_neg;
    mul_kind_e        s2_kind;
    tag_t             s2_tag;
    pp_t              s2_pp_lo;
    pp_t              s2_pp_hi;
    dword_t           prod;
    dword_t           prod_signed;
    xlen_t            full_res;

    // ------------------------------
    // Decode and operand magnitudes
    // ------------------------------
    assign issue_ok = issue_i & ~funct3_i[F3_DIV_BIT];  // Division group dropped here

    always_comb begin
        case (funct3_i)
            F3_MUL:    kind = MUL_LO;
            F3_MULH:   kind = MUL_HI_SS;
            F3_MULHSU: kind = MUL_HI_SU;
            default:   kind = MUL_HI_UU;
        endcase
    end

    // Word form only looks at the low 32 bits
    assign op1 = word_i ? {{HALF_XLEN{rs1_i[HALF_XLEN-1]}}, rs1_i[HALF_XLEN-1:0]} : rs1_i;
    assign op2 = word_i ? {{HALF_XLEN{rs2_i[HALF_XLEN-1]}}, rs2_i[HALF_XLEN-1:0]} : rs2_i;

    always_comb begin
        sign1 = 1'b0;
        sign2 = 1'b0;
        case (kind)
            MUL_LO, MUL_HI_SS: begin
                sign1 = op1[XLEN-1];
                sign2 = op2[XLEN-1];
            end
            MUL_HI_SU: sign1 = op1[XLEN-1];
            default: ;  // Both unsigned
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_ok & ~kill_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_word <= word_i;
        s1_kind <= kind;
        s1_neg  <= sign1 ^ sign2;  // Product sign
        s1_tag  <= tag_i;
        s1_mag1 <= sign1 ? -op1 : op1;
        s1_mag2 <= sign2 ? -op2 : op2;
    end

    // Partial products against each half of rs2
    assign pp_lo = s1_mag1 * s1_mag2[HALF_XLEN-1:0];
    assign pp_hi = s1_mag1 * s1_mag2[XLEN-1:HALF_XLEN];

    assign word_lo = s1_neg ? -pp_lo[HALF_XLEN-1:0] : pp_lo[HALF_XLEN-1:0];

    // ------------------------------
    // Stage two and completion lanes
    // ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s2_valid       <= 1'b0;
            cpl.word_valid <= 1'b0;
            cpl.full_valid <= 1'b0;
        end else begin
            cpl.word_valid <= s1_valid & s1_word & ~kill_i;
            s2_valid       <= s1_valid & ~s1_word & ~kill_i;  // Word ops leave here
            cpl.full_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        cpl.word_cpl.tag  <= s1_tag;
        cpl.word_cpl.data <= {{HALF_XLEN{word_lo[HALF_XLEN-1]}}, word_lo};
        s2_neg            <= s1_neg;
        s2_kind           <= s1_kind;
        s2_tag            <= s1_tag;
        s2_pp_lo          <= pp_lo;
        s2_pp_hi          <= pp_hi;
        cpl.full_cpl.tag  <= s2_tag;
        cpl.full_cpl.data <= full_res;
    end

    assign prod        = {{HALF_XLEN{1'b0}}, s2_pp_lo} + {s2_pp_hi, {HALF_XLEN{1'b0}}};
    assign prod_signed = s2_neg ? -prod : prod;
    assign full_res    = (s2_kind == MUL_LO) ? prod_signed[XLEN-1:0]
                                             : prod_signed[2*XLEN-1:XLEN];

    // Word form only pairs with a plain MUL
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_ok && word_i |-> kind == MUL_LO);

endmodule

// File: hw/mul_cpl_if.sv
// ------------------------------
// Multiplier completion link
// Word lane and full-width lane, one-cycle pulses
// ------------------------------
interface mul_cpl_if
    import mul_pkg::*;
();

    logic word_valid;  // Word result this cycle
    cpl_t word_cpl;
    logic full_valid;  // Full-width result this cycle
    cpl_t full_cpl;

    modport unit (
        output word_valid,
        output word_cpl,
        output full_valid,
        output full_cpl
    );

    modport fifo (
        input word_valid,
        input word_cpl,
        input full_valid,
        input full_cpl
    );

endinterface

// File: hw/mul_pkg.sv
// ------------------------------
// Multiply subsystem package
// Widths, opcode fields, completion record and buffer sizing
// ------------------------------
package mul_pkg;

    localparam int XLEN       = 64;
    localparam int HALF_XLEN  = XLEN / 2;
    localparam int PP_W       = XLEN + HALF_XLEN;   // Operand times half operand
    localparam int TAG_W      = 4;
    localparam int NUM_TAGS   = 2 ** TAG_W;         // 16 destination registers
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;     // Holds 0 to FIFO_DEPTH

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [2*XLEN-1:0] dword_t;
    typedef logic [PP_W-1:0]   pp_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [2:0]        funct3_t;

    // ------------------------------
    // M-extension operation field
    // ------------------------------
    localparam funct3_t F3_MUL    = 3'b000;
    localparam funct3_t F3_MULH   = 3'b001;
    localparam funct3_t F3_MULHSU = 3'b010;
    localparam funct3_t F3_MULHU  = 3'b011;
    localparam int      F3_DIV_BIT = 2;  // Set for the division group

    typedef enum logic [1:0] {
        MUL_LO,     // Low half, MUL and MULW
        MUL_HI_SS,  // High half, signed x signed
        MUL_HI_SU,  // High half, signed x unsigned
        MUL_HI_UU   // High half, unsigned x unsigned
    } mul_kind_e;

    // Completion record, also the buffer entry
    typedef struct packed {
        tag_t  tag;
        xlen_t data;
    } cpl_t;

endpackage
